//--- verilog.f
hdl/amba_pkg.sv
hdl/dma_pkg.sv
hdl/word_fifo.sv
hdl/app_codec.sv
hdl/busreq_sm.sv
hdl/ahb_dma_master.sv
hdl/ahb_slave_regs.sv
hdl/demo_amba.sv
test/tb_demo_amba.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_demo_amba \
	-f verilog.f -o tb_demo_amba
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_demo_amba)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

//--- test/tb_demo_amba.sv
module tb_demo_amba import amba_pkg::*, dma_pkg::*; ();

	// About 100 words cross the bus twice with polling reads and stalls
	localparam int MAX_CYCLES = 20000;
	localparam int MEM_WORDS  = 1024;

	logic    hclk     = 1'b0;
	logic    arst_n_i = 1'b0;
	logic    hsel_i   = 1'b0;
	haddr_t  haddr_i  = '0;
	htrans_t htrans_i = HTRANS_IDLE;
	logic    hwrite_i = 1'b0;
	hsize_t  hsize_i  = HSIZE_WORD;
	hdata_t  hwdata_i = '0;
	logic    hgrant_i = 1'b0;
	hdata_t  hrdata_i = '0;
	logic    hready_i = 1'b1;
	hdata_t  hrdata_o;
	logic    hbusreq_o;
	haddr_t  haddr_o;
	htrans_t htrans_o;
	logic    hwrite_o;
	hsize_t  hsize_o;
	hburst_t hburst_o;
	hdata_t  hwdata_o;
	led_t    led_o;

	// Memory model reads from src_mem and writes to dst_mem
	hdata_t      src_mem [MEM_WORDS];
	hdata_t      dst_mem [MEM_WORDS];
	logic        dp_valid = 1'b0;
	logic        dp_write = 1'b0;
	logic [9:0]  dp_idx   = '0;
	logic        stall_en = 1'b0;
	logic        grant_en = 1'b1;
	logic [15:0] stall_lfsr = 16'd77;
	logic [15:0] data_lfsr  = 16'd77;

	hdata_t      src_q [$];
	string       cur_test = "";
	int          test_errs = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	int unsigned cycle_cnt = 0;

	demo_amba i_dut (
		.hclk     (hclk),
		.arst_n_i (arst_n_i),
		.hsel_i   (hsel_i),
		.haddr_i  (haddr_i),
		.htrans_i (htrans_i),
		.hwrite_i (hwrite_i),
		.hsize_i  (hsize_i),
		.hwdata_i (hwdata_i),
		.hrdata_o (hrdata_o),
		.hbusreq_o(hbusreq_o),
		.hgrant_i (hgrant_i),
		.haddr_o  (haddr_o),
		.htrans_o (htrans_o),
		.hwrite_o (hwrite_o),
		.hsize_o  (hsize_o),
		.hburst_o (hburst_o),
		.hwdata_o (hwdata_o),
		.hrdata_i (hrdata_i),
		.hready_i (hready_i),
		.led_o    (led_o)
	);

	always #4 hclk = ~hclk;

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Endian conversion of one word
	function automatic hdata_t byte_reverse(input hdata_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic hdata_t fill_word(input int idx);
		return 32'h5a5a_0000 + idx;
	endfunction

	always @(posedge hclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Bus slave model for the master port
	// Two LFSR bits per cycle pick the stalls
	always @(posedge hclk) begin
		stall_lfsr <= lfsr_next(lfsr_next(stall_lfsr));
		hready_i   <= !(stall_en && stall_lfsr[1] && stall_lfsr[0]);
		hgrant_i   <= hbusreq_o && grant_en;
		if (!arst_n_i) begin
			for (int i = 0; i < MEM_WORDS; i++)
				dst_mem[i] <= fill_word(i);
			dp_valid <= 1'b0;
		end else if (hready_i) begin
			dp_valid <= (htrans_o != HTRANS_IDLE);
			dp_write <= hwrite_o;
			dp_idx   <= haddr_o[11:2];
			if ((htrans_o != HTRANS_IDLE) && !hwrite_o)
				hrdata_i <= src_mem[haddr_o[11:2]];
			if (dp_valid && dp_write)
				dst_mem[dp_idx] <= hwdata_o;
			// AHB codes for a word transfer in an INCR burst
			if (htrans_o != HTRANS_IDLE) begin
				if (hsize_o !== 3'b010) begin
					$display("Fail %s: hsize expected %h, actual %h",
						cur_test, 3'b010, hsize_o);
					test_errs++;
				end
				if (hburst_o !== 3'b001) begin
					$display("Fail %s: hburst expected %h, actual %h",
						cur_test, 3'b001, hburst_o);
					test_errs++;
				end
			end
		end
	end

	task automatic ahb_write(input reg_addr_t offset, input hdata_t data);
		@(posedge hclk);
		hsel_i   <= 1'b1;
		haddr_i  <= {24'b0, offset};
		htrans_i <= HTRANS_NONSEQ;
		hwrite_i <= 1'b1;
		do @(posedge hclk); while (!hready_i);
		hsel_i   <= 1'b0;
		htrans_i <= HTRANS_IDLE;
		hwrite_i <= 1'b0;
		hwdata_i <= data;
		do @(posedge hclk); while (!hready_i);
	endtask

	task automatic ahb_read(input reg_addr_t offset, output hdata_t data);
		@(posedge hclk);
		hsel_i   <= 1'b1;
		haddr_i  <= {24'b0, offset};
		htrans_i <= HTRANS_NONSEQ;
		hwrite_i <= 1'b0;
		do @(posedge hclk); while (!hready_i);
		hsel_i   <= 1'b0;
		htrans_i <= HTRANS_IDLE;
		do @(posedge hclk); while (!hready_i);
		data = hrdata_o;
	endtask

	task automatic take_word(output hdata_t w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			data_lfsr = lfsr_next(data_lfsr);
			w = {w[30:0], data_lfsr[0]};
		end
	endtask

	task automatic load_source(input int base_idx, input int n);
		hdata_t w;
		src_q.delete();
		for (int i = 0; i < n; i++) begin
			take_word(w);
			src_mem[base_idx + i] = w;
			src_q.push_back(w);
		end
	endtask

	// Enable goes last so the copy starts on fresh registers
	task automatic program_copy(input haddr_t src, input haddr_t dst,
		input block_count_t count, input block_size_t size);
		ahb_write(REG_CTRL, 32'h0);
		ahb_write(REG_SRC, src);
		ahb_write(REG_DST, dst);
		ahb_write(REG_BLOCK, {11'b0, size, count});
		ahb_write(REG_CTRL, 32'h1);
	endtask

	task automatic wait_copy_done();
		hdata_t d;
		do ahb_read(REG_BLOCK, d); while (d[15:0] != 16'h0);
	endtask

	task automatic check_copy(input string name, input int dst_idx, input int n);
		hdata_t exp;
		for (int i = 0; i < n; i++) begin
			exp = byte_reverse(src_q[i]);
			if (dst_mem[dst_idx + i] !== exp) begin
				$display("Fail %s: word %0d expected %h, actual %h",
					name, i, exp, dst_mem[dst_idx + i]);
				test_errs++;
			end
		end
		// Word after the block must stay untouched
		if (dst_mem[dst_idx + n] !== fill_word(dst_idx + n)) begin
			$display("Fail %s: write past block end, expected %h, actual %h",
				name, fill_word(dst_idx + n), dst_mem[dst_idx + n]);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0) begin
			$display("%s: passed", name);
			n_pass++;
		end else begin
			$display("%s: failed with %0d errors", name, test_errs);
			n_fail++;
		end
		test_errs = 0;
	endtask

	task automatic register_readback();
		hdata_t d;
		ahb_write(REG_SRC, 32'h1234_5678);
		ahb_write(REG_DST, 32'h9abc_def0);
		ahb_write(REG_BLOCK, 32'h0005_0009);
		ahb_write(REG_LED, 32'h0000_00a5);
		ahb_read(REG_SRC, d);
		if (d !== 32'h1234_5678) begin
			$display("Fail register_readback: SRC expected %h, actual %h", 32'h1234_5678, d);
			test_errs++;
		end
		ahb_read(REG_DST, d);
		if (d !== 32'h9abc_def0) begin
			$display("Fail register_readback: DST expected %h, actual %h", 32'h9abc_def0, d);
			test_errs++;
		end
		ahb_read(REG_BLOCK, d);
		if (d !== 32'h0005_0009) begin
			$display("Fail register_readback: BLOCK expected %h, actual %h", 32'h0005_0009, d);
			test_errs++;
		end
		ahb_read(REG_LED, d);
		if (d !== 32'h0000_00a5) begin
			$display("Fail register_readback: LED expected %h, actual %h", 32'h0000_00a5, d);
			test_errs++;
		end
		if (led_o !== 8'ha5) begin
			$display("Fail register_readback: led_o expected %h, actual %h", 8'ha5, led_o);
			test_errs++;
		end
		finish_test("register_readback");
	endtask

	task automatic single_block_copy();
		cur_test = "single_block_copy";
		load_source(0, 4);
		program_copy(32'h000, 32'h800, 16'd1, 5'd4);
		wait_copy_done();
		check_copy("single_block_copy", 512, 4);
		finish_test("single_block_copy");
	endtask

	task automatic multi_block_copy();
		hdata_t d;
		cur_test = "multi_block_copy";
		load_source(64, 40);
		program_copy(32'h100, 32'h900, 16'd5, 5'd8);
		wait_copy_done();
		check_copy("multi_block_copy", 576, 40);
		// Both pointers advance by count * size * 4 bytes
		ahb_read(REG_SRC, d);
		if (d !== 32'h100 + 32'd160) begin
			$display("Fail multi_block_copy: SRC expected %h, actual %h", 32'h100 + 32'd160, d);
			test_errs++;
		end
		ahb_read(REG_DST, d);
		if (d !== 32'h900 + 32'd160) begin
			$display("Fail multi_block_copy: DST expected %h, actual %h", 32'h900 + 32'd160, d);
			test_errs++;
		end
		finish_test("multi_block_copy");
	endtask

	task automatic back_pressure_copy();
		cur_test = "back_pressure_copy";
		load_source(128, 48);
		stall_en <= 1'b1;
		program_copy(32'h200, 32'ha00, 16'd3, 5'd16);
		wait_copy_done();
		stall_en <= 1'b0;
		check_copy("back_pressure_copy", 640, 48);
		finish_test("back_pressure_copy");
	endtask

	task automatic enable_grant_gating();
		cur_test = "enable_grant_gating";
		load_source(192, 8);
		grant_en <= 1'b0;
		ahb_write(REG_CTRL, 32'h0);
		ahb_write(REG_SRC, 32'h300);
		ahb_write(REG_DST, 32'hb00);
		ahb_write(REG_BLOCK, {11'b0, 5'd4, 16'd2});
		repeat (50) begin
			@(posedge hclk);
			if (hbusreq_o) begin
				$display("Fail enable_grant_gating: hbusreq expected %b, actual %b",
					1'b0, hbusreq_o);
				test_errs++;
			end
		end
		ahb_write(REG_CTRL, 32'h1);
		while (!hbusreq_o)
			@(posedge hclk);
		// No transfer may start before the grant
		repeat (20) begin
			@(posedge hclk);
			if (htrans_o !== HTRANS_IDLE) begin
				$display("Fail enable_grant_gating: htrans expected %h, actual %h",
					HTRANS_IDLE, htrans_o);
				test_errs++;
			end
		end
		grant_en <= 1'b1;
		wait_copy_done();
		check_copy("enable_grant_gating", 704, 8);
		finish_test("enable_grant_gating");
	endtask

	initial begin
		repeat (5) @(posedge hclk);
		arst_n_i <= 1'b1;
		@(posedge hclk);
		register_readback();
		single_block_copy();
		multi_block_copy();
		back_pressure_copy();
		enable_grant_gating();
		$display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- hdl/demo_amba.sv
module demo_amba import amba_pkg::*, dma_pkg::*; (
	input  logic    hclk,
	input  logic    arst_n_i,
	// Register slave port
	input  logic    hsel_i,
	input  haddr_t  haddr_i,
	input  htrans_t htrans_i,
	input  logic    hwrite_i,
	input  hsize_t  hsize_i,
	input  hdata_t  hwdata_i,
	output hdata_t  hrdata_o,
	// DMA master port
	output logic    hbusreq_o,
	input  logic    hgrant_i,
	output haddr_t  haddr_o,
	output htrans_t htrans_o,
	output logic    hwrite_o,
	output hsize_t  hsize_o,
	output hburst_t hburst_o,
	output hdata_t  hwdata_o,
	input  hdata_t  hrdata_i,
	// Shared bus ready
	input  logic    hready_i,
	output led_t    led_o
);

	haddr_t       src_addr;
	haddr_t       dst_addr;
	block_count_t block_count;
	block_size_t  block_size;
	logic         dma_en;
	logic         rd_req;
	logic         wr_req;
	logic         rd_update;
	logic         wr_update;
	logic         req_done;

	// Input FIFO, master to codec
	logic         in_push;
	logic         in_pop;
	hdata_t       in_wdata;
	hdata_t       in_rdata;
	fifo_level_t  in_level;

	// Output FIFO, codec to master
	logic         out_push;
	logic         out_pop;
	hdata_t       out_wdata;
	hdata_t       out_rdata;
	fifo_level_t  out_level;

	ahb_slave_regs i_slave (
		.hclk         (hclk),
		.arst_n_i     (arst_n_i),
		.hsel_i       (hsel_i),
		.haddr_i      (haddr_i),
		.htrans_i     (htrans_i),
		.hwrite_i     (hwrite_i),
		.hsize_i      (hsize_i),
		.hwdata_i     (hwdata_i),
		.hready_i     (hready_i),
		.rd_update_i  (rd_update),
		.wr_update_i  (wr_update),
		.hrdata_o     (hrdata_o),
		.src_addr_o   (src_addr),
		.dst_addr_o   (dst_addr),
		.block_count_o(block_count),
		.block_size_o (block_size),
		.dma_en_o     (dma_en),
		.led_o        (led_o)
	);

	ahb_dma_master i_master (
		.hclk        (hclk),
		.arst_n_i    (arst_n_i),
		.hready_i    (hready_i),
		.hgrant_i    (hgrant_i),
		.hrdata_i    (hrdata_i),
		.rd_req_i    (rd_req),
		.wr_req_i    (wr_req),
		.src_addr_i  (src_addr),
		.dst_addr_i  (dst_addr),
		.block_size_i(block_size),
		.fifo_rdata_i(out_rdata),
		.hbusreq_o   (hbusreq_o),
		.htrans_o    (htrans_o),
		.hwrite_o    (hwrite_o),
		.hsize_o     (hsize_o),
		.hburst_o    (hburst_o),
		.haddr_o     (haddr_o),
		.hwdata_o    (hwdata_o),
		.req_done_o  (req_done),
		.fifo_push_o (in_push),
		.fifo_wdata_o(in_wdata),
		.fifo_pop_o  (out_pop)
	);

	busreq_sm i_busreq (
		.hclk         (hclk),
		.arst_n_i     (arst_n_i),
		.dma_en_i     (dma_en),
		.block_count_i(block_count),
		.block_size_i (block_size),
		.in_level_i   (in_level),
		.out_level_i  (out_level),
		.req_done_i   (req_done),
		.rd_req_o     (rd_req),
		.wr_req_o     (wr_req),
		.rd_update_o  (rd_update),
		.wr_update_o  (wr_update)
	);

	word_fifo in_fifo (
		.hclk    (hclk),
		.arst_n_i(arst_n_i),
		.push_i  (in_push),
		.pop_i   (in_pop),
		.din_i   (in_wdata),
		.dout_o  (in_rdata),
		.full_o  (),
		.empty_o (),
		.level_o (in_level)
	);

	word_fifo out_fifo (
		.hclk    (hclk),
		.arst_n_i(arst_n_i),
		.push_i  (out_push),
		.pop_i   (out_pop),
		.din_i   (out_wdata),
		.dout_o  (out_rdata),
		.full_o  (),
		.empty_o (),
		.level_o (out_level)
	);

	app_codec i_codec (
		.hclk        (hclk),
		.arst_n_i    (arst_n_i),
		.block_size_i(block_size),
		.in_level_i  (in_level),
		.out_level_i (out_level),
		.in_data_i   (in_rdata),
		.pop_o       (in_pop),
		.push_o      (out_push),
		.out_data_o  (out_wdata)
	);

endmodule

//--- hdl/ahb_slave_regs.sv
module ahb_slave_regs import amba_pkg::*, dma_pkg::*; (
	input  logic         hclk,
	input  logic         arst_n_i,
	input  logic         hsel_i,
	input  haddr_t       haddr_i,
	input  htrans_t      htrans_i,
	input  logic         hwrite_i,
	input  hsize_t       hsize_i,
	input  hdata_t       hwdata_i,
	input  logic         hready_i,
	input  logic         rd_update_i,
	input  logic         wr_update_i,
	output hdata_t       hrdata_o,
	output haddr_t       src_addr_o,
	output haddr_t       dst_addr_o,
	output block_count_t block_count_o,
	output block_size_t  block_size_o,
	output logic         dma_en_o,
	output led_t         led_o
);

	reg_addr_t addr_q;
	logic      wr_pend;
	logic      wr_commit;
	haddr_t    block_bytes;

	assign wr_commit   = wr_pend && hready_i;
	assign block_bytes = haddr_t'({block_size_o, 2'b00});

	// Address phase capture
	always_ff @(posedge hclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			addr_q  <= '0;
			wr_pend <= 1'b0;
		end else if (hready_i) begin
			addr_q  <= haddr_i[7:0];
			wr_pend <= hsel_i && hwrite_i && (hsize_i == HSIZE_WORD) &&
				((htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ));
		end
	end

	// DMA registers, a bus write wins over a pointer update
	always_ff @(posedge hclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			src_addr_o    <= '0;
			dst_addr_o    <= '0;
			block_count_o <= '0;
			block_size_o  <= '0;
			dma_en_o      <= 1'b0;
			led_o         <= '0;
		end else begin
			if (rd_update_i)
				src_addr_o <= src_addr_o + block_bytes;
			if (wr_update_i) begin
				dst_addr_o    <= dst_addr_o + block_bytes;
				block_count_o <= block_count_o - 1'b1;
			end
			if (wr_commit) begin
				case (addr_q)
					REG_CTRL:  dma_en_o <= hwdata_i[0];
					REG_SRC:   src_addr_o <= hwdata_i;
					REG_DST:   dst_addr_o <= hwdata_i;
					REG_BLOCK: begin
						block_count_o <= hwdata_i[15:0];
						block_size_o  <= hwdata_i[20:16];
					end
					REG_LED:   led_o <= hwdata_i[7:0];
					default: ;
				endcase
			end
		end
	end

	// Read mux on the captured offset
	always_comb begin
		case (addr_q)
			REG_CTRL:  hrdata_o = {31'b0, dma_en_o};
			REG_SRC:   hrdata_o = src_addr_o;
			REG_DST:   hrdata_o = dst_addr_o;
			REG_BLOCK: hrdata_o = {11'b0, block_size_o, block_count_o};
			REG_LED:   hrdata_o = {24'b0, led_o};
			default:   hrdata_o = '0;
		endcase
	end

	// Sequencer finishes one request at a time
	a_single_update: assert property (@(posedge hclk) disable iff (!arst_n_i)
		!(rd_update_i && wr_update_i));

endmodule

//--- hdl/ahb_dma_master.sv
module ahb_dma_master import amba_pkg::*, dma_pkg::*; (
	input  logic        hclk,
	input  logic        arst_n_i,
	input  logic        hready_i,
	input  logic        hgrant_i,
	input  hdata_t      hrdata_i,
	input  logic        rd_req_i,
	input  logic        wr_req_i,
	input  haddr_t      src_addr_i,
	input  haddr_t      dst_addr_i,
	input  block_size_t block_size_i,
	input  hdata_t      fifo_rdata_i,
	output logic        hbusreq_o,
	output htrans_t     htrans_o,
	output logic        hwrite_o,
	output hsize_t      hsize_o,
	output hburst_t     hburst_o,
	output haddr_t      haddr_o,
	output hdata_t      hwdata_o,
	output logic        req_done_o,
	output logic        fifo_push_o,
	output hdata_t      fifo_wdata_o,
	output logic        fifo_pop_o
);

	master_state_t state;
	block_size_t   addr_left;
	block_size_t   data_left;
	logic          dphase_q;
	logic          data_ack;

	assign hsize_o  = HSIZE_WORD;
	assign hburst_o = HBURST_INCR;

	assign data_ack     = dphase_q && hready_i;
	assign fifo_push_o  = data_ack && !hwrite_o;
	assign fifo_wdata_o = hrdata_i;
	// Next write word leaves the FIFO as its address phase is accepted
	assign fifo_pop_o   = (state == MS_ADDR) && hwrite_o && hready_i;

	always_ff @(posedge hclk) begin
		if (fifo_pop_o)
			hwdata_o <= fifo_rdata_i;
	end

	always_ff @(posedge hclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= MS_IDLE;
			hbusreq_o  <= 1'b0;
			htrans_o   <= HTRANS_IDLE;
			hwrite_o   <= 1'b0;
			haddr_o    <= '0;
			addr_left  <= '0;
			data_left  <= '0;
			dphase_q   <= 1'b0;
			req_done_o <= 1'b0;
		end else begin
			req_done_o <= 1'b0;
			// Data phase follows every accepted address phase
			if (hready_i)
				dphase_q <= (htrans_o != HTRANS_IDLE);
			if (data_ack)
				data_left <= data_left - 1'b1;

			case (state)
				MS_IDLE: begin
					// Request is still high in the req_done cycle
					if ((rd_req_i || wr_req_i) && !req_done_o) begin
						state     <= MS_REQ;
						hbusreq_o <= 1'b1;
						hwrite_o  <= wr_req_i;
						haddr_o   <= wr_req_i ? dst_addr_i : src_addr_i;
						addr_left <= block_size_i;
						data_left <= block_size_i;
					end
				end
				MS_REQ: begin
					if (hgrant_i && hready_i) begin
						state     <= MS_ADDR;
						htrans_o  <= HTRANS_NONSEQ;
						addr_left <= addr_left - 1'b1;
					end
				end
				MS_ADDR: begin
					if (hready_i) begin
						if (addr_left == '0) begin
							state     <= MS_LAST;
							htrans_o  <= HTRANS_IDLE;
							hbusreq_o <= 1'b0;
						end else begin
							htrans_o  <= HTRANS_SEQ;
							haddr_o   <= haddr_o + 32'd4;
							addr_left <= addr_left - 1'b1;
						end
					end
				end
				MS_LAST: begin
					if (data_ack && (data_left == block_size_t'(1))) begin
						state      <= MS_IDLE;
						req_done_o <= 1'b1;
					end
				end
				default: state <= MS_IDLE;
			endcase
		end
	end

	// A SEQ beat continues a burst already under way
	a_seq_in_burst: assert property (@(posedge hclk) disable iff (!arst_n_i)
		(htrans_o == HTRANS_SEQ) |->
		($past(htrans_o) == HTRANS_NONSEQ || $past(htrans_o) == HTRANS_SEQ));

endmodule

//--- hdl/busreq_sm.sv
module busreq_sm import dma_pkg::*; (
	input  logic         hclk,
	input  logic         arst_n_i,
	input  logic         dma_en_i,
	input  block_count_t block_count_i,
	input  block_size_t  block_size_i,
	input  fifo_level_t  in_level_i,
	input  fifo_level_t  out_level_i,
	input  logic         req_done_i,
	output logic         rd_req_o,
	output logic         wr_req_o,
	output logic         rd_update_o,
	output logic         wr_update_o
);

	busreq_state_t state;
	block_count_t  inflight;
	fifo_level_t   size_lvl;
	logic          rd_go;
	logic          wr_go;

	assign size_lvl = fifo_level_t'(block_size_i);

	// A whole block waits in the output FIFO
	assign wr_go = (block_size_i != '0) && (out_level_i >= size_lvl);
	// Blocks left beyond those in flight, and room in the input FIFO
	assign rd_go = dma_en_i && (block_size_i != '0) && (block_count_i > inflight) &&
		(in_level_i <= fifo_level_t'(FIFO_DEPTH) - size_lvl);

	assign rd_req_o    = (state == BR_READ);
	assign wr_req_o    = (state == BR_WRITE);
	assign rd_update_o = rd_req_o && req_done_i;
	assign wr_update_o = wr_req_o && req_done_i;

	always_ff @(posedge hclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state    <= BR_IDLE;
			inflight <= '0;
		end else begin
			case (state)
				BR_IDLE: begin
					// Drain first
					if (wr_go)
						state <= BR_WRITE;
					else if (rd_go)
						state <= BR_READ;
				end
				BR_READ: begin
					if (req_done_i) begin
						state    <= BR_IDLE;
						inflight <= inflight + 1'b1;
					end
				end
				BR_WRITE: begin
					if (req_done_i) begin
						state    <= BR_IDLE;
						inflight <= inflight - 1'b1;
					end
				end
				default: state <= BR_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/app_codec.sv
module app_codec import amba_pkg::*, dma_pkg::*; (
	input  logic        hclk,
	input  logic        arst_n_i,
	input  block_size_t block_size_i,
	input  fifo_level_t in_level_i,
	input  fifo_level_t out_level_i,
	input  hdata_t      in_data_i,
	output logic        pop_o,
	output logic        push_o,
	output hdata_t      out_data_o
);

	codec_state_t state;
	block_size_t  pop_left;
	fifo_level_t  size_lvl;
	logic         start;

	assign size_lvl = fifo_level_t'(block_size_i);

	// Whole block available and room for all of it downstream
	assign start = (block_size_i != '0) && (in_level_i >= size_lvl) &&
		(out_level_i <= fifo_level_t'(FIFO_DEPTH) - size_lvl);

	assign pop_o = (state == CS_RUN) && (pop_left != '0);

	// Byte reversal, one stage
	always_ff @(posedge hclk) begin
		if (pop_o)
			out_data_o <= {in_data_i[7:0], in_data_i[15:8],
				in_data_i[23:16], in_data_i[31:24]};
	end

	always_ff @(posedge hclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state    <= CS_IDLE;
			pop_left <= '0;
			push_o   <= 1'b0;
		end else begin
			push_o <= pop_o;
			case (state)
				CS_IDLE: begin
					if (start) begin
						state    <= CS_RUN;
						pop_left <= block_size_i;
					end
				end
				CS_RUN: begin
					if (pop_o)
						pop_left <= pop_left - 1'b1;
					// All popped, last push goes out this cycle
					else
						state <= CS_IDLE;
				end
				default: state <= CS_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/word_fifo.sv
module word_fifo import amba_pkg::*, dma_pkg::*; (
	input  logic        hclk,
	input  logic        arst_n_i,
	input  logic        push_i,
	input  logic        pop_i,
	input  hdata_t      din_i,
	output hdata_t      dout_o,
	output logic        full_o,
	output logic        empty_o,
	output fifo_level_t level_o
);

	hdata_t    mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;

	// First word falls through
	assign dout_o  = mem[rd_ptr];
	assign full_o  = (level_o == fifo_level_t'(FIFO_DEPTH));
	assign empty_o = (level_o == '0);

	always_ff @(posedge hclk) begin
		if (push_i)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge hclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level_o <= '0;
		end else begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_i, pop_i})
				2'b10:   level_o <= level_o + 1'b1;
				2'b01:   level_o <= level_o - 1'b1;
				default: ;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge hclk) disable iff (!arst_n_i)
		full_o |-> !push_i);
	a_no_underflow: assert property (@(posedge hclk) disable iff (!arst_n_i)
		empty_o |-> !pop_i);

endmodule

//--- hdl/dma_pkg.sv
package dma_pkg;

	// Register map, byte offsets within the slave
	typedef logic [7:0] reg_addr_t;
	localparam reg_addr_t REG_CTRL  = 8'h00;
	localparam reg_addr_t REG_SRC   = 8'h04;
	localparam reg_addr_t REG_DST   = 8'h08;
	localparam reg_addr_t REG_BLOCK = 8'h0C;
	localparam reg_addr_t REG_LED   = 8'h10;

	// DMA fields
	typedef logic [15:0] block_count_t;
	typedef logic [4:0]  block_size_t;
	typedef logic [7:0]  led_t;

	// Word FIFOs
	localparam int FIFO_DEPTH = 32;
	typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
	typedef logic [$clog2(FIFO_DEPTH):0]   fifo_level_t;

	// State machines
	typedef enum logic [1:0] {BR_IDLE, BR_READ, BR_WRITE} busreq_state_t;
	typedef enum logic [1:0] {MS_IDLE, MS_REQ, MS_ADDR, MS_LAST} master_state_t;
	typedef enum logic {CS_IDLE, CS_RUN} codec_state_t;

endpackage

//--- hdl/amba_pkg.sv
package amba_pkg;

	// Bus widths
	typedef logic [31:0] haddr_t;
	typedef logic [31:0] hdata_t;
	typedef logic [1:0]  htrans_t;
	typedef logic [2:0]  hsize_t;
	typedef logic [2:0]  hburst_t;

	// Transfer types
	localparam htrans_t HTRANS_IDLE   = 2'b00;
	localparam htrans_t HTRANS_NONSEQ = 2'b10;
	localparam htrans_t HTRANS_SEQ    = 2'b11;

	// 32-bit transfers only
	localparam hsize_t HSIZE_WORD = 3'b010;

	// Undefined-length incrementing burst
	localparam hburst_t HBURST_INCR = 3'b001;

endpackage
